/* srt_div.f */
src/srt_div_pkg.sv
src/qds_params_if.sv
src/div_ctrl.sv
src/div_prescale.sv
src/srt_r4_iter.sv
src/div_postprocess.sv
src/srt_div.sv
tests/srt_div_props.sv
tests/srt_div_checker.sv
tests/srt_div_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the srt divider testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module srt_div_tb -Mdir obj_dir -f srt_div.f

./obj_dir/Vsrt_div_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

/* tests/srt_div_tb.sv */
// ====================
// testbench for the srt divider
// lfsr driven operations against a division model
// back-pressure and flush runs, watchdog and summary
// ====================
`timescale 1ns/1ps
`default_nettype none

module srt_div_tb import srt_div_pkg::*; ();

	localparam int CLK_NS     = 40;
	localparam int N_UNS      = 150;
	localparam int N_SGN      = 150;
	localparam int N_DIR      = 4;
	localparam int N_ZERO     = 16;
	localparam int N_SMALL    = 40;
	localparam int N_HOLD     = 80;
	localparam int N_FLUSH    = 40;
	// each flush run is followed by one normal operation
	localparam int N_OPS      = N_UNS + N_SGN + N_DIR + N_ZERO + N_SMALL + N_HOLD + 2 * N_FLUSH;
	localparam int CYC_PER_OP = 30;
	localparam longint WATCHDOG_NS = longint'(N_OPS * CYC_PER_OP + 200) * CLK_NS;

	logic  clk;
	logic  rst_n;
	logic  start_valid;
	logic  flush;
	logic  signed_op;
	logic  finish_ready;
	data_t dividend;
	data_t divisor;
	logic  start_ready;
	logic  finish_valid;
	logic  is_zero;
	data_t quotient;
	data_t remainder;
	data_t exp_quo;
	data_t exp_rem;
	logic  exp_zero;
	int    chk_errs;
	int    chk_cnt;
	int    tb_errs = 0;
	data_t lfsr_state;

	srt_div srt_div_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.div_start_valid_i  (start_valid),
		.flush_i            (flush),
		.signed_op_i        (signed_op),
		.div_finish_ready_i (finish_ready),
		.dividend_i         (dividend),
		.divisor_i          (divisor),
		.div_start_ready_o  (start_ready),
		.div_finish_valid_o (finish_valid),
		.divisor_is_zero_o  (is_zero),
		.quotient_o         (quotient),
		.remainder_o        (remainder)
	);

	srt_div_checker u_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid),
		.start_ready_i  (start_ready),
		.finish_valid_i (finish_valid),
		.finish_ready_i (finish_ready),
		.flush_i        (flush),
		.quotient_i     (quotient),
		.remainder_i    (remainder),
		.zero_i         (is_zero),
		.exp_quo_i      (exp_quo),
		.exp_rem_i      (exp_rem),
		.exp_zero_i     (exp_zero),
		.err_cnt_o      (chk_errs),
		.chk_cnt_o      (chk_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before all operations finished", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	// ====================
	// stimulus helpers
	// ====================
	// galois form, taps 32 22 2 1
	function automatic data_t lfsr_next(input data_t s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic data_t rand_bits(input int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[DIV_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// random dividend, divisor scaled down so the step count varies
	task automatic pick_operands(output data_t a, output data_t b);
		data_t sh;
		a  = rand_bits(32);
		b  = rand_bits(32);
		sh = rand_bits(5);
		b  = b >> sh;
	endtask

	// truncating division, remainder keeps the dividend sign
	task automatic compute_expected(input data_t a, input data_t b, input logic sgn,
			output data_t q, output data_t r, output logic z);
		longint na;
		longint nb;
		longint lq;
		longint lr;
		z = (b == '0);
		if (z) begin
			q = '1;
			r = a;
		end else begin
			na = sgn ? longint'($signed(a)) : longint'({{DIV_W{1'b0}}, a});
			nb = sgn ? longint'($signed(b)) : longint'({{DIV_W{1'b0}}, b});
			lq = na / nb;
			lr = na % nb;
			// min / -1 wraps back to min in 32 bits
			q = lq[DIV_W-1:0];
			r = lr[DIV_W-1:0];
		end
	endtask

	// one operation from start to finish or flush
	task automatic run_op(input data_t a, input data_t b, input logic sgn,
			input logic hold, input logic do_flush);
		data_t q;
		data_t r;
		logic  z;
		int    delay;
		int    held;
		compute_expected(a, b, sgn, q, r, z);
		@(negedge clk);
		dividend    = a;
		divisor     = b;
		signed_op   = sgn;
		exp_quo     = q;
		exp_rem     = r;
		exp_zero    = z;
		start_valid = 1'b1;
		// divider is idle, this edge takes the start
		@(negedge clk);
		start_valid = 1'b0;
		if (do_flush) begin
			delay = int'(rand_bits(4));
			repeat (delay) @(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
			if (!start_ready || finish_valid) begin
				$display("flush at %0t ns did not bring the divider back to idle", $time);
				tb_errs++;
			end
		end else begin
			held = 0;
			forever begin
				if (finish_valid) begin
					if (!hold || held >= 6 || rand_bits(1) != 0) begin
						finish_ready = 1'b1;
						start_valid  = 1'b0;
						@(negedge clk);
						finish_ready = 1'b0;
						break;
					end
					held++;
				end
				// starts offered while busy must be refused
				if (hold)
					start_valid = (rand_bits(1) != 0);
				@(negedge clk);
			end
		end
	endtask

	task automatic end_test(input string name, input int ops, input int errs_before);
		$display("test %-14s %0d operations, %0d errors", name, ops,
			chk_errs + tb_errs - errs_before);
	endtask

	// ====================
	// test sequence
	// ====================
	initial begin : main
		data_t a;
		data_t b;
		logic  sgn;
		int    errs_before;
		int    total;
		rst_n        = 1'b0;
		start_valid  = 1'b0;
		flush        = 1'b0;
		signed_op    = 1'b0;
		finish_ready = 1'b0;
		dividend     = '0;
		divisor      = '0;
		exp_quo      = '0;
		exp_rem      = '0;
		exp_zero     = 1'b0;
		lfsr_state   = 32'haa94_742e;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_UNS; i++) begin
			pick_operands(a, b);
			run_op(a, b, 1'b0, 1'b0, 1'b0);
		end
		end_test("unsigned", N_UNS, errs_before);

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_SGN; i++) begin
			pick_operands(a, b);
			if (rand_bits(1) != 0)
				b = -b;
			run_op(a, b, 1'b1, 1'b0, 1'b0);
		end
		// overflow corner and the four sign pairs
		run_op(32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0, 1'b0);
		run_op(-32'd7, 32'd2, 1'b1, 1'b0, 1'b0);
		run_op(32'd7, -32'd2, 1'b1, 1'b0, 1'b0);
		run_op(-32'd7, -32'd2, 1'b1, 1'b0, 1'b0);
		end_test("signed", N_SGN + N_DIR, errs_before);

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_ZERO; i++) begin
			a   = rand_bits(32);
			sgn = (rand_bits(1) != 0);
			run_op(a, '0, sgn, 1'b0, 1'b0);
		end
		end_test("zero divisor", N_ZERO, errs_before);

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_SMALL; i++) begin
			b = rand_bits(32) | 32'd1;
			a = b >> (rand_bits(4) + 32'd1);
			run_op(a, b, 1'b0, 1'b0, 1'b0);
		end
		end_test("small dividend", N_SMALL, errs_before);

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_HOLD; i++) begin
			pick_operands(a, b);
			sgn = (rand_bits(1) != 0);
			run_op(a, b, sgn, 1'b1, 1'b0);
		end
		end_test("back-pressure", N_HOLD, errs_before);

		errs_before = chk_errs + tb_errs;
		for (int i = 0; i < N_FLUSH; i++) begin
			pick_operands(a, b);
			run_op(a, b, 1'b0, 1'b0, 1'b1);
			pick_operands(a, b);
			sgn = (rand_bits(1) != 0);
			run_op(a, b, sgn, 1'b0, 1'b0);
		end
		end_test("flush", 2 * N_FLUSH, errs_before);

		// flushed operations give no result
		if (chk_cnt != N_OPS - N_FLUSH) begin
			$display("checked %0d results but %0d operations should have finished",
				chk_cnt, N_OPS - N_FLUSH);
			tb_errs++;
		end
		total = chk_errs + tb_errs;
		$display("summary: %0d results checked, %0d errors", chk_cnt, total);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/srt_div_checker.sv */
// ====================
// result checker for the srt divider
// queues the expected results at each accepted start
// and compares them at each accepted finish
// also watches the outputs under back-pressure
// ====================
`timescale 1ns/1ps
`default_nettype none

module srt_div_checker import srt_div_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  start_valid_i,
	input  logic  start_ready_i,
	input  logic  finish_valid_i,
	input  logic  finish_ready_i,
	input  logic  flush_i,
	input  data_t quotient_i,
	input  data_t remainder_i,
	input  logic  zero_i,
	input  data_t exp_quo_i,
	input  data_t exp_rem_i,
	input  logic  exp_zero_i,
	output int    err_cnt_o,
	output int    chk_cnt_o
);

	// zero flag, quotient and remainder in one entry
	logic [2*DIV_W:0] pend_q[$];
	logic [2*DIV_W:0] held_val;
	logic             held = 1'b0;
	int               errs = 0;
	int               checked = 0;

	assign err_cnt_o = errs;
	assign chk_cnt_o = checked;

	task automatic value_error(input string what, input data_t got, input data_t exp);
		$display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		errs++;
	endtask

	task automatic protocol_error(input string what);
		$display("protocol failure at %0t ns: %s", $time, what);
		errs++;
	endtask

	// outputs are registers, so at the edge they still show the last cycle
	always @(posedge clk) begin : watch
		logic [2*DIV_W:0] exp_v;
		if (rst_n) begin
			if (start_ready_i && finish_valid_i)
				protocol_error("start ready and finish valid are high together");
			// result must not move while it waits
			if (held && finish_valid_i && {zero_i, quotient_i, remainder_i} != held_val)
				protocol_error("result changed while finish was held back");

			if (flush_i) begin
				// a busy divider throws its operation away
				if (!start_ready_i && pend_q.size() > 0)
					void'(pend_q.pop_back());
				held = 1'b0;
			end else if (finish_valid_i && finish_ready_i) begin
				held = 1'b0;
				if (pend_q.size() == 0) begin
					protocol_error("finish handshake with no operation pending");
				end else begin
					exp_v = pend_q.pop_front();
					checked++;
					if (quotient_i != exp_v[2*DIV_W-1:DIV_W])
						value_error("quotient", quotient_i, exp_v[2*DIV_W-1:DIV_W]);
					if (remainder_i != exp_v[DIV_W-1:0])
						value_error("remainder", remainder_i, exp_v[DIV_W-1:0]);
					if (zero_i != exp_v[2*DIV_W])
						value_error("zero flag", data_t'(zero_i), data_t'(exp_v[2*DIV_W]));
				end
			end else if (finish_valid_i) begin
				held     = 1'b1;
				held_val = {zero_i, quotient_i, remainder_i};
			end

			if (start_valid_i && start_ready_i && !flush_i) begin
				if (pend_q.size() != 0)
					protocol_error("start accepted while a result is still pending");
				pend_q.push_back({exp_zero_i, exp_quo_i, exp_rem_i});
			end
		end else begin
			held = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tests/srt_div_props.sv */
// ====================
// handshake properties of the divider controller
// bound into div_ctrl
// ====================
`timescale 1ns/1ps
`default_nettype none

module srt_div_props import srt_div_pkg::*; (
	input logic              clk,
	input logic              rst_n,
	input logic              start_valid_i,
	input logic              start_ready_i,
	input logic              finish_valid_i,
	input logic              finish_ready_i,
	input logic              flush_i,
	input logic              pre0_i,
	input logic              iter_i,
	input logic [ITER_W-1:0] iter_cnt_i
);

	// a 32-bit quotient never needs more than 17 radix-4 steps
	assert property (@(posedge clk) disable iff (!rst_n)
		iter_i |-> iter_cnt_i < ITER_W'(DIV_W / 2 + 1))
		else $error("iteration counter above the longest division");

	// an offered result waits for ready
	assert property (@(posedge clk) disable iff (!rst_n)
		finish_valid_i && !finish_ready_i && !flush_i |=> finish_valid_i)
		else $error("finish valid dropped without a handshake");

	// flush lands in IDLE one edge later
	assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |=> start_ready_i && !finish_valid_i)
		else $error("flush did not return the controller to idle");

	// accepted start moves on to PRE0
	assert property (@(posedge clk) disable iff (!rst_n)
		start_valid_i && start_ready_i && !flush_i |=> pre0_i)
		else $error("accepted start did not enter PRE0");

endmodule

bind div_ctrl srt_div_props u_props (
	.clk            (clk),
	.rst_n          (rst_n),
	.start_valid_i  (start_valid_i),
	.start_ready_i  (start_ready_o),
	.finish_valid_i (finish_valid_o),
	.finish_ready_i (finish_ready_i),
	.flush_i        (flush_i),
	.pre0_i         (pre0_o),
	.iter_i         (iter_o),
	.iter_cnt_i     (iter_cnt_q)
);

`default_nettype wire

/* src/srt_div.sv */
// ====================
// 32-bit radix-4 SRT integer divider
// signed and unsigned with valid/ready start and finish
// flush and a divide by zero flag
// ====================
`timescale 1ns/1ps
`default_nettype none

module srt_div import srt_div_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  div_start_valid_i,
	input  logic  flush_i,
	input  logic  signed_op_i,
	input  logic  div_finish_ready_i,
	input  data_t dividend_i,
	input  data_t divisor_i,
	output logic  div_start_ready_o,
	output logic  div_finish_valid_o,
	output logic  divisor_is_zero_o,
	output data_t quotient_o,
	output data_t remainder_o
);

	logic              idle;
	logic              pre0;
	logic              pre1;
	logic              iter;
	logic              post0;
	logic              bypass;
	logic              quo_sign;
	logic              rem_sign;
	logic [ITER_W-1:0] iter_num;
	rem_t              rem_init;
	rem_t              rem_fin;
	data_t             norm_divisor;
	data_t             dividend_abs;
	data_t             quo;
	data_t             quo_m1;
	lzc_t              divisor_lzc;

	qds_params_if qds_if ();

	div_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (div_start_valid_i),
		.finish_ready_i (div_finish_ready_i),
		.flush_i        (flush_i),
		.bypass_i       (bypass),
		.iter_num_i     (iter_num),
		.start_ready_o  (div_start_ready_o),
		.finish_valid_o (div_finish_valid_o),
		.idle_o         (idle),
		.pre0_o         (pre0),
		.pre1_o         (pre1),
		.iter_o         (iter),
		.post0_o        (post0)
	);

	div_prescale u_prescale (
		.clk            (clk),
		.dividend_i     (dividend_i),
		.divisor_i      (divisor_i),
		.signed_op_i    (signed_op_i),
		.idle_i         (idle),
		.start_i        (div_start_valid_i),
		.pre0_i         (pre0),
		.pre1_i         (pre1),
		.qds            (qds_if.prescale),
		.bypass_o       (bypass),
		.divisor_zero_o (divisor_is_zero_o),
		.quo_sign_o     (quo_sign),
		.rem_sign_o     (rem_sign),
		.iter_num_o     (iter_num),
		.rem_init_o     (rem_init),
		.norm_divisor_o (norm_divisor),
		.dividend_abs_o (dividend_abs),
		.divisor_lzc_o  (divisor_lzc)
	);

	srt_r4_iter u_iter (
		.clk            (clk),
		.pre1_i         (pre1),
		.iter_i         (iter),
		.bypass_i       (bypass),
		.divisor_zero_i (divisor_is_zero_o),
		.rem_init_i     (rem_init),
		.norm_divisor_i (norm_divisor),
		.dividend_abs_i (dividend_abs),
		.qds            (qds_if.iter),
		.rem_o          (rem_fin),
		.quo_o          (quo),
		.quo_m1_o       (quo_m1)
	);

	div_postprocess u_post (
		.clk            (clk),
		.post0_i        (post0),
		.bypass_i       (bypass),
		.quo_sign_i     (quo_sign),
		.rem_sign_i     (rem_sign),
		.divisor_zero_i (divisor_is_zero_o),
		.rem_i          (rem_fin),
		.norm_divisor_i (norm_divisor),
		.quo_i          (quo),
		.quo_m1_i       (quo_m1),
		.dividend_abs_i (dividend_abs),
		.divisor_lzc_i  (divisor_lzc),
		.quotient_o     (quotient_o),
		.remainder_o    (remainder_o)
	);

endmodule

`default_nettype wire

/* src/div_postprocess.sv */
// ====================
// divider post-processing
// remainder correction and quotient choice
// denormalising shift and sign restore
// ====================
`timescale 1ns/1ps
`default_nettype none

module div_postprocess import srt_div_pkg::*; (
	input  logic  clk,
	input  logic  post0_i,
	input  logic  bypass_i,
	input  logic  quo_sign_i,
	input  logic  rem_sign_i,
	input  logic  divisor_zero_i,
	input  rem_t  rem_i,
	input  data_t norm_divisor_i,
	input  data_t quo_i,
	input  data_t quo_m1_i,
	input  data_t dividend_abs_i,
	input  lzc_t  divisor_lzc_i,
	output data_t quotient_o,
	output data_t remainder_o
);

	logic  need_corr;
	logic  quo_neg;
	rem_t  rem_fix;
	data_t rem_pre;
	data_t rem_abs;
	data_t quo_abs;

	// ====================
	// correction
	// ====================
	// negative final remainder means one too many
	assign need_corr = rem_i[ITN_W-1] & ~bypass_i;
	assign rem_fix   = need_corr ? rem_i + {3'b000, norm_divisor_i, 3'b000} : rem_i;
	assign quo_abs   = need_corr ? quo_m1_i : quo_i;

	// drop the alignment bits
	assign rem_pre = rem_fix[DIV_W+2:3];

	// undo the divisor normalisation
	// bypass already holds the plain dividend
	assign rem_abs = bypass_i ? dividend_abs_i : (rem_pre >> divisor_lzc_i);

	// all-ones quotient of x / 0 stays unsigned
	assign quo_neg = quo_sign_i & ~divisor_zero_i;

	// ====================
	// result registers
	// ====================
	// held through POST1 until the result is taken
	always_ff @(posedge clk) begin
		if (post0_i) begin
			quotient_o  <= quo_neg ? -quo_abs : quo_abs;
			// remainder follows the dividend sign
			remainder_o <= rem_sign_i ? -rem_abs : rem_abs;
		end
	end

endmodule

`default_nettype wire

/* src/srt_r4_iter.sv */
// ====================
// radix-4 SRT iteration
// one digit in -2..+2 per cycle on a plain remainder
// with on-the-fly quotient conversion
// ====================
`timescale 1ns/1ps
`default_nettype none

module srt_r4_iter import srt_div_pkg::*; (
	input  logic       clk,
	input  logic       pre1_i,
	input  logic       iter_i,
	input  logic       bypass_i,
	input  logic       divisor_zero_i,
	input  rem_t       rem_init_i,
	input  data_t      norm_divisor_i,
	input  data_t      dividend_abs_i,
	qds_params_if.iter qds,
	output rem_t       rem_o,
	output data_t      quo_o,
	output data_t      quo_m1_o
);

	rem_t                     rem_q;
	data_t                    quo_q;
	data_t                    qm_q;
	rem_t                     rem_x4;
	rem_t                     div_x1;
	rem_t                     div_x2;
	logic signed [QTHR_W:0]   rem_est;
	logic signed [QTHR_W:0]   thr_neg1;
	logic signed [QTHR_W:0]   thr_neg0;
	logic signed [QTHR_W:0]   thr_pos1;
	logic signed [QTHR_W:0]   thr_pos2;
	qdigit_t                  qdig;
	rem_t                     rem_nxt;
	data_t                    quo_nxt;
	data_t                    qm_nxt;
	data_t                    quo_init;

	// divisor multiples aligned to the remainder fraction
	assign div_x1 = {3'b000, norm_divisor_i, 3'b000};
	assign div_x2 = div_x1 << 1;

	assign rem_x4 = rem_q << 2;
	// 4w truncated to 1/16
	assign rem_est = rem_x4[ITN_W-1 -: QTHR_W+1];

	assign thr_neg1 = {qds.m_neg1[QTHR_W-1], qds.m_neg1};
	assign thr_neg0 = {qds.m_neg0[QTHR_W-1], qds.m_neg0};
	assign thr_pos1 = {qds.m_pos1[QTHR_W-1], qds.m_pos1};
	assign thr_pos2 = {qds.m_pos2[QTHR_W-1], qds.m_pos2};

	// ====================
	// digit selection
	// ====================
	always_comb begin
		if (rem_est >= thr_pos2)
			qdig = QDIG_POS2;
		else if (rem_est >= thr_pos1)
			qdig = QDIG_POS1;
		else if (rem_est >= thr_neg0)
			qdig = QDIG_ZERO;
		else if (rem_est >= thr_neg1)
			qdig = QDIG_NEG1;
		else
			qdig = QDIG_NEG2;
	end

	// w' = 4w - q*d and the two quotient forms
	always_comb begin
		// zero digit
		rem_nxt = rem_x4;
		quo_nxt = {quo_q[DIV_W-3:0], 2'b00};
		qm_nxt  = {qm_q[DIV_W-3:0], 2'b11};
		case (qdig)
			QDIG_POS2: begin
				rem_nxt = rem_x4 - div_x2;
				quo_nxt = {quo_q[DIV_W-3:0], 2'b10};
				qm_nxt  = {quo_q[DIV_W-3:0], 2'b01};
			end
			QDIG_POS1: begin
				rem_nxt = rem_x4 - div_x1;
				quo_nxt = {quo_q[DIV_W-3:0], 2'b01};
				qm_nxt  = {quo_q[DIV_W-3:0], 2'b00};
			end
			// negative digits borrow from q-1
			QDIG_NEG1: begin
				rem_nxt = rem_x4 + div_x1;
				quo_nxt = {qm_q[DIV_W-3:0], 2'b11};
				qm_nxt  = {qm_q[DIV_W-3:0], 2'b10};
			end
			QDIG_NEG2: begin
				rem_nxt = rem_x4 + div_x2;
				quo_nxt = {qm_q[DIV_W-3:0], 2'b10};
				qm_nxt  = {qm_q[DIV_W-3:0], 2'b01};
			end
			default: begin
			end
		endcase
	end

	// all ones for a zero divisor
	assign quo_init = {DIV_W{divisor_zero_i}};

	always_ff @(posedge clk) begin
		if (pre1_i) begin
			// bypass parks the dividend as a non-negative remainder
			rem_q <= bypass_i ? {3'b000, dividend_abs_i, 3'b000} : rem_init_i;
			quo_q <= quo_init;
			qm_q  <= quo_init - data_t'(1);
		end else if (iter_i) begin
			rem_q <= rem_nxt;
			quo_q <= quo_nxt;
			qm_q  <= qm_nxt;
		end
	end

	assign rem_o    = rem_q;
	assign quo_o    = quo_q;
	assign quo_m1_o = qm_q;

endmodule

`default_nettype wire

/* src/div_prescale.sv */
// ====================
// divider prescale stage
// operand magnitudes and signs and leading zero counts
// normalisation and the bypass decision
// the step count and the threshold table
// ====================
`timescale 1ns/1ps
`default_nettype none

module div_prescale import srt_div_pkg::*; (
	input  logic              clk,
	input  data_t             dividend_i,
	input  data_t             divisor_i,
	input  logic              signed_op_i,
	input  logic              idle_i,
	input  logic              start_i,
	input  logic              pre0_i,
	input  logic              pre1_i,
	qds_params_if.prescale    qds,
	output logic              bypass_o,
	output logic              divisor_zero_o,
	output logic              quo_sign_o,
	output logic              rem_sign_o,
	output logic [ITER_W-1:0] iter_num_o,
	output rem_t              rem_init_o,
	output data_t             norm_divisor_o,
	output data_t             dividend_abs_o,
	output lzc_t              divisor_lzc_o
);

	// priority search for the highest set bit
	// an all-zero input counts as DIV_W
	function automatic lzc_t count_lz(input data_t v);
		lzc_t n;
		n = lzc_t'(DIV_W);
		for (int i = 0; i < DIV_W; i++) begin
			if (v[i])
				n = lzc_t'(DIV_W - 1 - i);
		end
		return n;
	endfunction

	logic                  dividend_sign;
	logic                  divisor_sign;
	data_t                 dividend_abs;
	data_t                 divisor_abs;
	data_t                 dividend_abs_q;
	data_t                 divisor_abs_q;
	logic                  quo_sign_q;
	logic                  rem_sign_q;
	lzc_t                  dividend_lzc;
	lzc_t                  divisor_lzc;
	lzc_t                  dividend_lzc_q;
	lzc_t                  divisor_lzc_q;
	data_t                 norm_dividend_q;
	data_t                 norm_divisor_q;
	logic                  bypass_q;
	logic [LZC_W-2:0]      lzc_diff;
	lzc_t                  iter_sum;
	logic [4*QTHR_W-1:0]   thr_tab;

	assign dividend_sign = signed_op_i & dividend_i[DIV_W-1];
	assign divisor_sign  = signed_op_i & divisor_i[DIV_W-1];
	assign dividend_abs  = dividend_sign ? -dividend_i : dividend_i;
	assign divisor_abs   = divisor_sign ? -divisor_i : divisor_i;

	assign dividend_lzc = count_lz(dividend_abs_q);
	assign divisor_lzc  = count_lz(divisor_abs_q);

	// ====================
	// step count and alignment
	// ====================
	// n = ceil((diff + 2) / 2) leaves a 2 or 3 bit pre-shift
	assign lzc_diff   = divisor_lzc_q[LZC_W-2:0] - dividend_lzc_q[LZC_W-2:0];
	assign iter_sum   = {1'b0, lzc_diff} + lzc_t'(3);
	assign iter_num_o = iter_sum[ITER_W:1];
	// first remainder is the normalised dividend over 4 or 8
	assign rem_init_o = lzc_diff[0] ? {6'b000000, norm_dividend_q}
		: {5'b00000, norm_dividend_q, 1'b0};

	// thresholds by the three bits under the leading one
	// order m[-1] m[0] m[+1] m[+2] in 1/16 units
	always_comb begin
		case (norm_divisor_q[DIV_W-2 -: 3])
			3'd0: thr_tab = {-6'sd13, -6'sd4, 6'sd4, 6'sd12};
			3'd1: thr_tab = {-6'sd15, -6'sd6, 6'sd4, 6'sd14};
			3'd2: thr_tab = {-6'sd16, -6'sd6, 6'sd4, 6'sd15};
			3'd3: thr_tab = {-6'sd17, -6'sd6, 6'sd4, 6'sd16};
			3'd4: thr_tab = {-6'sd19, -6'sd6, 6'sd6, 6'sd18};
			3'd5: thr_tab = {-6'sd20, -6'sd8, 6'sd6, 6'sd20};
			3'd6: thr_tab = {-6'sd22, -6'sd8, 6'sd6, 6'sd22};
			default: thr_tab = {-6'sd24, -6'sd8, 6'sd8, 6'sd22};
		endcase
	end

	always_ff @(posedge clk) begin
		// magnitudes and signs at the accepted start
		if (idle_i & start_i) begin
			dividend_abs_q <= dividend_abs;
			divisor_abs_q  <= divisor_abs;
			// x / 0 keeps an all-ones quotient
			quo_sign_q     <= (dividend_sign ^ divisor_sign) & (|divisor_i);
			rem_sign_q     <= dividend_sign;
		end
		if (pre0_i) begin
			dividend_lzc_q  <= dividend_lzc;
			divisor_lzc_q   <= divisor_lzc;
			norm_dividend_q <= dividend_abs_q << dividend_lzc;
			norm_divisor_q  <= divisor_abs_q << divisor_lzc;
			// zero divisor or fewer significant dividend bits
			bypass_q        <= divisor_lzc[LZC_W-1] | (dividend_lzc > divisor_lzc);
		end
		if (pre1_i)
			{qds.m_neg1, qds.m_neg0, qds.m_pos1, qds.m_pos2} <= thr_tab;
	end

	assign bypass_o       = bypass_q;
	assign divisor_zero_o = divisor_lzc_q[LZC_W-1];
	assign quo_sign_o     = quo_sign_q;
	assign rem_sign_o     = rem_sign_q;
	assign norm_divisor_o = norm_divisor_q;
	assign dividend_abs_o = dividend_abs_q;
	assign divisor_lzc_o  = divisor_lzc_q;

endmodule

`default_nettype wire

/* src/div_ctrl.sv */
// ====================
// divider controller
// state machine with the iteration down-counter
// and the start and finish handshake
// ====================
`timescale 1ns/1ps
`default_nettype none

module div_ctrl import srt_div_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start_valid_i,
	input  logic              finish_ready_i,
	input  logic              flush_i,
	input  logic              bypass_i,
	input  logic [ITER_W-1:0] iter_num_i,
	output logic              start_ready_o,
	output logic              finish_valid_o,
	output logic              idle_o,
	output logic              pre0_o,
	output logic              pre1_o,
	output logic              iter_o,
	output logic              post0_o
);

	div_state_e        state_q;
	div_state_e        state_d;
	logic [ITER_W-1:0] iter_cnt_q;

	// ====================
	// next state
	// ====================
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start_valid_i)
					state_d = PRE0;
			end
			PRE0: state_d = PRE1;
			// nothing to iterate for a zero divisor or a small dividend
			PRE1: state_d = bypass_i ? POST0 : ITER;
			ITER: begin
				if (iter_cnt_q == '0)
					state_d = POST0;
			end
			POST0: state_d = POST1;
			POST1: begin
				if (finish_ready_i)
					state_d = IDLE;
			end
			default: state_d = IDLE;
		endcase
		// flush wins over everything
		if (flush_i)
			state_d = IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// counts the remaining steps down to zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			iter_cnt_q <= '0;
		else if (pre1_o)
			iter_cnt_q <= iter_num_i - ITER_W'(1);
		else if (iter_o)
			iter_cnt_q <= iter_cnt_q - ITER_W'(1);
	end

	// state strobes for the datapath
	assign idle_o  = (state_q == IDLE);
	assign pre0_o  = (state_q == PRE0);
	assign pre1_o  = (state_q == PRE1);
	assign iter_o  = (state_q == ITER);
	assign post0_o = (state_q == POST0);

	assign start_ready_o  = idle_o;
	assign finish_valid_o = (state_q == POST1);

endmodule

`default_nettype wire

/* src/qds_params_if.sv */
// ====================
// quotient digit selection thresholds
// loaded by the prescale stage in PRE1
// and held for the radix-4 iteration
// ====================
`timescale 1ns/1ps
`default_nettype none

interface qds_params_if import srt_div_pkg::*; ();

	// signed thresholds between neighbouring digits
	qthr_t m_neg1;
	qthr_t m_neg0;
	qthr_t m_pos1;
	qthr_t m_pos2;

	modport prescale (
		output m_neg1, m_neg0, m_pos1, m_pos2
	);

	modport iter (
		input m_neg1, m_neg0, m_pos1, m_pos2
	);

endinterface

`default_nettype wire

/* src/srt_div_pkg.sv */
// ====================
// srt divider package
// widths and vector types shared by the divider stages
// plus the quotient digit codes and the controller states
// ====================
`default_nettype none

package srt_div_pkg;

	// operand and result width
	localparam int DIV_W = 32;
	// leading zero count with room for the all-zero value
	localparam int LZC_W = 6;
	// remainder keeps sign and two integer bits over 35 fraction bits
	localparam int ITN_W = DIV_W + 6;
	// up to 17 radix-4 steps for a 32-bit quotient
	localparam int ITER_W = 5;
	// selection threshold in units of 1/16
	localparam int QTHR_W = 6;
	localparam int QDIG_W = 5;

	typedef logic [DIV_W-1:0] data_t;
	typedef logic [LZC_W-1:0] lzc_t;
	typedef logic [ITN_W-1:0] rem_t;
	typedef logic [QTHR_W-1:0] qthr_t;
	typedef logic [QDIG_W-1:0] qdigit_t;

	// one-hot quotient digits
	// bit 0 stands for -2 and bit 4 for +2
	localparam qdigit_t QDIG_NEG2 = 5'b00001;
	localparam qdigit_t QDIG_NEG1 = 5'b00010;
	localparam qdigit_t QDIG_ZERO = 5'b00100;
	localparam qdigit_t QDIG_POS1 = 5'b01000;
	localparam qdigit_t QDIG_POS2 = 5'b10000;

	// controller states in processing order
	typedef enum logic [2:0] {
		IDLE,
		PRE0,
		PRE1,
		ITER,
		POST0,
		POST1
	} div_state_e;

endpackage

`default_nettype wire
